/* Makefile */
VERILATOR ?= verilator
TOP       ?= hub75_tb
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0

SIM     := $(OBJ_DIR)/V$(TOP)
SOURCES := $(filter-out +%,$(shell cat $(FILELIST))) $(wildcard *.svh)

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -q -F '=== PASS ==='

clean:
	rm -rf $(OBJ_DIR)

/* all.f */
+incdir+.
hub75_pkg.sv
hub75_row_buffer.sv
hub75_plane_slicer.sv
hub75_column_shifter.sv
hub75_scan_ctrl.sv
hub75_top.sv
tb_clock_gen.sv
hub75_props.sv
hub75_tb.sv

/* hub75_column_shifter.sv */
`timescale 1ns/1ps

module hub75_column_shifter
  import hub75_pkg::*;
(
  input  logic        clk,
  input  logic        rst,
  input  lane_bits_t  lane0,
  input  lane_bits_t  lane1,
  input  logic        lanes_valid,
  output logic        lanes_ready,
  output shift_done_t done,
  output logic        done_valid,
  input  logic        done_ready,
  output logic [2:0]  rgb0,
  output logic [2:0]  rgb1,
  output logic        sclk
);

  logic busy_q;
  logic last_q;
  logic accept;

  // a new column may load on the edge that drops sclk, except after the last one
  assign lanes_ready = !done_valid && (!busy_q || (sclk && !last_q));
  assign accept      = lanes_valid && lanes_ready;

  always_ff @(posedge clk) begin
    if (rst) begin
      busy_q     <= 1'b0;
      sclk       <= 1'b0;
      done_valid <= 1'b0;
    end else begin
      if (done_valid && done_ready) begin
        done_valid <= 1'b0;
      end
      if (accept) begin
        busy_q <= 1'b1;
        sclk   <= 1'b0; // data settles for a cycle with sclk low
      end else if (busy_q && !sclk) begin
        sclk <= 1'b1;
      end else if (busy_q) begin
        sclk   <= 1'b0;
        busy_q <= 1'b0;
        if (last_q) begin
          done_valid <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      rgb0   <= lane0.rgb;
      rgb1   <= lane1.rgb;
      last_q <= lane0.last;
      done   <= '{plane: lane0.plane}; // both lanes run in lockstep
    end
  end

endmodule

/* hub75_pkg.sv */
`include "hub75_settings.svh"

package hub75_pkg;

  localparam int PLANE_W = $clog2(`HUB75_DEPTH);

  typedef struct packed {
    logic [`HUB75_DEPTH-1:0] r;
    logic [`HUB75_DEPTH-1:0] g;
    logic [`HUB75_DEPTH-1:0] b;
  } pixel_t;

  typedef struct packed {
    pixel_t top;
    pixel_t bot;
  } pix_pair_t;

  typedef struct packed {
    pixel_t             pix;
    logic [PLANE_W-1:0] plane;
    logic               last; // final column of the row
  } plane_pix_t;

  typedef struct packed {
    logic [2:0]         rgb; // r is the msb
    logic [PLANE_W-1:0] plane;
    logic               last;
  } lane_bits_t;

  typedef struct packed {
    logic [PLANE_W-1:0] plane;
  } shift_done_t;

  typedef struct packed {
    logic [2:0] rgb0;
    logic [2:0] rgb1;
    logic       sclk;
    logic [3:0] addr;
    logic       latch;
    logic       oe_n;
  } hub75_pins_t;

  typedef enum logic [1:0] {IDLE, LATCH, SHOW} scan_state_e;
  typedef enum logic {FILL, REPLAY} buf_state_e;

endpackage

/* hub75_plane_slicer.sv */
`timescale 1ns/1ps

module hub75_plane_slicer
  import hub75_pkg::*;
(
  input  logic       clk,
  input  logic       rst,
  input  plane_pix_t in_pix,
  input  logic       in_valid,
  output logic       in_ready,
  output lane_bits_t out_bits,
  output logic       out_valid,
  input  logic       out_ready
);

  logic take;

  assign in_ready = !out_valid || out_ready;
  assign take     = in_valid && in_ready;

  always_ff @(posedge clk) begin
    if (rst) begin
      out_valid <= 1'b0;
    end else if (take) begin
      out_valid <= 1'b1;
    end else if (out_ready) begin
      out_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (take) begin
      out_bits <= '{rgb:   {in_pix.pix.r[in_pix.plane], in_pix.pix.g[in_pix.plane],
                            in_pix.pix.b[in_pix.plane]},
                    plane: in_pix.plane,
                    last:  in_pix.last};
    end
  end

endmodule

/* hub75_props.sv */
`timescale 1ns/1ps

module hub75_props
  import hub75_pkg::*;
(
  input logic        clk,
  input logic        rst,
  input pix_pair_t   in_pix,
  input logic        in_valid,
  input logic        in_ready,
  input logic        done_valid,
  input logic        done_ready,
  input hub75_pins_t pins
);

  // the panel stays blank while a plane moves into the output latches
  oe_off_at_latch: assert property (@(posedge clk) disable iff (rst) pins.latch |-> pins.oe_n)
    else $error("oe_n is low while latch is high");

  rgb_stable_sclk: assert property (@(posedge clk) disable iff (rst)
    pins.sclk |-> ($stable(pins.rgb0) && $stable(pins.rgb1)))
    else $error("colour pins changed while sclk was high");

  in_held: assert property (@(posedge clk) disable iff (rst)
    (in_valid && !in_ready) |=> (in_valid && $stable(in_pix)))
    else $error("pixel input dropped or changed before it was accepted");

  done_held: assert property (@(posedge clk) disable iff (rst)
    (done_valid && !done_ready) |=> done_valid)
    else $error("shift done withdrawn before the scan controller took it");

  latch_single: assert property (@(posedge clk) disable iff (rst) pins.latch |=> !pins.latch)
    else $error("latch was high for two cycles in a row");

endmodule

/* hub75_row_buffer.sv */
`timescale 1ns/1ps
`include "hub75_settings.svh"

module hub75_row_buffer
  import hub75_pkg::*;
(
  input  logic       clk,
  input  logic       rst,
  input  pix_pair_t  in_pix,
  input  logic       in_valid,
  output logic       in_ready,
  output plane_pix_t top_pix,
  output plane_pix_t bot_pix,
  output logic       out_valid,
  input  logic       out_ready
);

  localparam int COL_W = $clog2(`HUB75_COLS);

  pix_pair_t          row_q [`HUB75_COLS];
  buf_state_e         state_q;
  logic [COL_W-1:0]   col_q;
  logic [PLANE_W-1:0] plane_q;
  logic               last_col;

  assign last_col  = (col_q == COL_W'(`HUB75_COLS - 1));
  assign in_ready  = (state_q == FILL);
  assign out_valid = (state_q == REPLAY);

  assign top_pix = '{pix: row_q[col_q].top, plane: plane_q, last: last_col};
  assign bot_pix = '{pix: row_q[col_q].bot, plane: plane_q, last: last_col};

  always_ff @(posedge clk) begin
    if (in_valid && in_ready) begin
      row_q[col_q] <= in_pix;
    end
  end

  // one column counter serves both the fill and every replay pass
  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= FILL;
      col_q   <= '0;
      plane_q <= '0;
    end else begin
      case (state_q)
        FILL: begin
          if (in_valid) begin
            if (last_col) begin
              col_q   <= '0;
              plane_q <= '0;
              state_q <= REPLAY;
            end else begin
              col_q <= col_q + 1'b1;
            end
          end
        end
        REPLAY: begin
          if (out_ready) begin
            if (last_col) begin
              col_q <= '0;
              if (plane_q == PLANE_W'(`HUB75_DEPTH - 1)) begin
                plane_q <= '0;
                state_q <= FILL; // row fully shown, take the next one
              end else begin
                plane_q <= plane_q + 1'b1;
              end
            end else begin
              col_q <= col_q + 1'b1;
            end
          end
        end
        default: state_q <= FILL;
      endcase
    end
  end

endmodule

/* hub75_scan_ctrl.sv */
`timescale 1ns/1ps
`include "hub75_settings.svh"

module hub75_scan_ctrl
  import hub75_pkg::*;
(
  input  logic        clk,
  input  logic        rst,
  input  logic        dim,
  input  shift_done_t done,
  input  logic        done_valid,
  output logic        done_ready,
  output logic [3:0]  addr,
  output logic        latch,
  output logic        oe_n
);

  localparam int MAX_SHOW = `HUB75_SHOW_UNIT << (`HUB75_DEPTH - 1);
  localparam int CNT_W    = $clog2(MAX_SHOW + 1);

  scan_state_e        state_q;
  logic [PLANE_W-1:0] plane_q;
  logic [CNT_W-1:0]   cnt_q;
  logic [CNT_W-1:0]   full_len;
  logic [CNT_W-1:0]   show_len;
  logic               last_plane;

  // binary-coded weight, dim halves the on-time
  assign full_len   = CNT_W'(`HUB75_SHOW_UNIT) << plane_q;
  assign show_len   = dim ? (full_len >> 1) : full_len;
  assign last_plane = (plane_q == PLANE_W'(`HUB75_DEPTH - 1));

  assign done_ready = (state_q == IDLE);
  assign latch      = (state_q == LATCH);
  assign oe_n       = (state_q != SHOW); // panel is blanked while latching

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= IDLE;
      plane_q <= '0;
      cnt_q   <= '0;
      addr    <= '0;
    end else begin
      case (state_q)
        IDLE: begin
          if (done_valid) begin
            plane_q <= done.plane;
            state_q <= LATCH;
          end
        end
        LATCH: begin
          cnt_q   <= show_len; // dim is taken once per plane here
          state_q <= SHOW;
        end
        SHOW: begin
          if (cnt_q <= CNT_W'(1)) begin
            state_q <= IDLE;
            if (last_plane) begin
              if (addr == 4'(`HUB75_ROWS - 1)) begin
                addr <= '0;
              end else begin
                addr <= addr + 1'b1;
              end
            end
          end else begin
            cnt_q <= cnt_q - 1'b1;
          end
        end
        default: state_q <= IDLE;
      endcase
    end
  end

endmodule

/* hub75_settings.svh */
`ifndef HUB75_SETTINGS_SVH
`define HUB75_SETTINGS_SVH

// panel geometry, the panel has twice this many rows
`define HUB75_COLS 32
`define HUB75_ROWS 16

// bits per colour channel
`define HUB75_DEPTH 4
`define HUB75_SHOW_UNIT 4 // on-cycles for the lowest plane

`endif

/* hub75_tb.sv */
`timescale 1ns/1ps
`include "hub75_settings.svh"

module hub75_tb
  import hub75_pkg::*;
();

  localparam int ROWS_RUN    = 20; // enough to wrap the 16-row address
  localparam int PLANES      = `HUB75_DEPTH;
  localparam int TOTAL_SHOWS = ROWS_RUN * PLANES;
  localparam int WATCHDOG_NS = ROWS_RUN * PLANES *
    (2 * `HUB75_COLS + 2 + 8 * `HUB75_SHOW_UNIT * (1 << `HUB75_DEPTH)) * 10 * 2;

  logic        clk;
  logic        rst;
  logic        dim;
  pix_pair_t   in_pix;
  logic        in_valid;
  logic        in_ready;
  hub75_pins_t pins;

  pix_pair_t  row_data [ROWS_RUN][`HUB75_COLS];
  logic       row_dim [ROWS_RUN + 1];
  logic [5:0] seen_cols [$]; // {rgb0, rgb1} per sclk rise
  int         lat_row = 0;
  int         lat_plane = 0;
  int         show_row = 0;
  int         show_plane = 0;
  int         on_count = 0;
  int         shows_done = 0;
  int         dim_row = 0;
  logic       prev_sclk;
  logic       prev_oe_n;
  logic       prev_in_ready;

  tb_clock_gen u_clk_gen (.clk(clk), .rst(rst));

  hub75_top DUT (
    .clk(clk), .rst(rst), .dim(dim),
    .in_pix(in_pix), .in_valid(in_valid), .in_ready(in_ready),
    .pins(pins)
  );

  bind hub75_top hub75_props u_props (
    .clk(clk), .rst(rst), .in_pix(in_pix), .in_valid(in_valid), .in_ready(in_ready),
    .done_valid(done_valid), .done_ready(done_ready), .pins(pins)
  );

  function automatic logic [5:0] plane_bits(pix_pair_t pp, logic [PLANE_W-1:0] p);
    return {pp.top.r[p], pp.top.g[p], pp.top.b[p], pp.bot.r[p], pp.bot.g[p], pp.bot.b[p]};
  endfunction

  function automatic int expected_on_time(int p, logic dimmed);
    int len;
    len = (1 << p) * `HUB75_SHOW_UNIT;
    return dimmed ? len / 2 : len;
  endfunction

  task automatic stop_with_failure(input string line);
    $display("%s", line);
    $display("=== FAIL ===");
    $fatal(1, "stopping at the first error");
  endtask

  task automatic check_equal(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (actual !== expected) begin
      stop_with_failure($sformatf("MISMATCH %s: expected %0h, actual %0h",
                                  name, expected, actual));
    end
  endtask

  task automatic send_row(input int r);
    logic accepted;
    int   gap;
    for (int c = 0; c < `HUB75_COLS; c++) begin
      row_data[r][c] = 24'($urandom);
      gap = $urandom_range(0, 3);
      in_valid = 1'b0;
      repeat (gap) begin
        @(posedge clk);
        #1;
      end
      in_pix   = row_data[r][c];
      in_valid = 1'b1;
      accepted = 1'b0;
      while (!accepted) begin
        @(negedge clk);
        accepted = in_ready;
        @(posedge clk);
        #1;
      end
    end
    in_valid = 1'b0;
    check_equal("in_ready after last pixel", 32'(0), 32'(in_ready));
  endtask

  task automatic check_latched_plane();
    if (lat_row >= ROWS_RUN) begin
      stop_with_failure("ERROR: a plane was latched after every row had been shown");
    end
    check_equal("latch addr", 32'(lat_row % `HUB75_ROWS), 32'(pins.addr));
    check_equal("columns shifted", 32'(`HUB75_COLS), 32'(seen_cols.size()));
    check_equal("oe_n low before latch", 32'(0), 32'(on_count));
    for (int c = 0; c < `HUB75_COLS; c++) begin
      check_equal($sformatf("row %0d plane %0d col %0d", lat_row, lat_plane, c),
                  32'(plane_bits(row_data[lat_row][c], PLANE_W'(lat_plane))),
                  32'(seen_cols[c]));
    end
    seen_cols.delete();
    show_row   = lat_row;
    show_plane = lat_plane;
    if (lat_plane == PLANES - 1) begin
      lat_plane = 0;
      lat_row++;
      dim_row = lat_row; // next row's dim goes out after this latch
    end else begin
      lat_plane++;
    end
  endtask

  // panel model sampled mid-cycle where every pin is settled
  always @(negedge clk) begin
    if (rst) begin
      prev_sclk     = 1'b0;
      prev_oe_n     = 1'b1;
      prev_in_ready = 1'b1;
    end else begin
      if (pins.sclk && !prev_sclk) begin
        seen_cols.push_back({pins.rgb0, pins.rgb1});
      end
      if (!pins.oe_n) begin
        on_count++;
      end
      if (pins.oe_n && !prev_oe_n) begin
        check_equal($sformatf("on-time row %0d plane %0d", show_row, show_plane),
                    32'(expected_on_time(show_plane, row_dim[show_row])), 32'(on_count));
        on_count = 0;
        shows_done++;
      end
      if (pins.latch) begin
        check_latched_plane();
      end
      if (in_ready && !prev_in_ready) begin
        check_equal("plane pending when in_ready returns", 32'(PLANES - 1), 32'(lat_plane));
      end
      prev_sclk     = pins.sclk;
      prev_oe_n     = pins.oe_n;
      prev_in_ready = in_ready;
    end
  end

  initial begin
    forever begin
      @(posedge clk);
      #1;
      dim = row_dim[dim_row];
    end
  end

  initial begin
    #(WATCHDOG_NS);
    $display("ERROR: watchdog expired after %0d ns with %0d of %0d planes shown",
             WATCHDOG_NS, shows_done, TOTAL_SHOWS);
    $display("=== FAIL ===");
    $fatal(1, "watchdog timeout");
  end

  initial begin
    int seed_val;
    seed_val = $urandom(73239);
    in_valid = 1'b0;
    in_pix   = '0;
    dim      = 1'b0;
    for (int r = 0; r <= ROWS_RUN; r++) begin
      row_dim[r] = 1'($urandom_range(0, 1));
    end
    @(negedge clk);
    while (rst) @(negedge clk);
    check_equal("latch after reset", 32'(0), 32'(pins.latch));
    check_equal("oe_n after reset", 32'(1), 32'(pins.oe_n));
    check_equal("sclk after reset", 32'(0), 32'(pins.sclk));
    check_equal("addr after reset", 32'(0), 32'(pins.addr));
    check_equal("in_ready after reset", 32'(1), 32'(in_ready));
    @(posedge clk);
    #1;
    for (int r = 0; r < ROWS_RUN; r++) begin
      send_row(r);
    end
    wait (shows_done == TOTAL_SHOWS);
    @(negedge clk);
    check_equal("planes latched", 32'(TOTAL_SHOWS), 32'(lat_row * PLANES + lat_plane));
    $display("=== PASS ===");
    $finish;
  end

endmodule

/* hub75_top.sv */
`timescale 1ns/1ps

module hub75_top
  import hub75_pkg::*;
(
  input  logic        clk,
  input  logic        rst,
  input  logic        dim,
  input  pix_pair_t   in_pix,
  input  logic        in_valid,
  output logic        in_ready,
  output hub75_pins_t pins
);

  plane_pix_t  half_pix [2];
  lane_bits_t  lane     [2];
  logic [1:0]  slc_ready;
  logic [1:0]  lane_valid;
  logic        buf_valid;
  logic        buf_ready;
  logic        lanes_valid;
  logic        lanes_ready;
  shift_done_t done;
  logic        done_valid;
  logic        done_ready;
  logic [2:0]  rgb0;
  logic [2:0]  rgb1;
  logic        sclk;
  logic [3:0]  addr;
  logic        latch;
  logic        oe_n;

  assign buf_ready   = &slc_ready;
  assign lanes_valid = &lane_valid;

  assign pins = '{rgb0: rgb0, rgb1: rgb1, sclk: sclk, addr: addr, latch: latch, oe_n: oe_n};

  hub75_row_buffer u_row_buffer (
    .clk(clk), .rst(rst),
    .in_pix(in_pix), .in_valid(in_valid), .in_ready(in_ready),
    .top_pix(half_pix[0]), .bot_pix(half_pix[1]),
    .out_valid(buf_valid), .out_ready(buf_ready)
  );

  // index 0 is the top half of the panel, 1 the bottom half
  for (genvar h = 0; h < 2; h++) begin : g_half
    hub75_plane_slicer u_slicer (
      .clk(clk), .rst(rst),
      .in_pix(half_pix[h]), .in_valid(buf_valid), .in_ready(slc_ready[h]),
      .out_bits(lane[h]), .out_valid(lane_valid[h]), .out_ready(lanes_ready)
    );
  end

  hub75_column_shifter u_shifter (
    .clk(clk), .rst(rst),
    .lane0(lane[0]), .lane1(lane[1]),
    .lanes_valid(lanes_valid), .lanes_ready(lanes_ready),
    .done(done), .done_valid(done_valid), .done_ready(done_ready),
    .rgb0(rgb0), .rgb1(rgb1), .sclk(sclk)
  );

  hub75_scan_ctrl u_scan_ctrl (
    .clk(clk), .rst(rst), .dim(dim),
    .done(done), .done_valid(done_valid), .done_ready(done_ready),
    .addr(addr), .latch(latch), .oe_n(oe_n)
  );

endmodule

/* tb_clock_gen.sv */
`timescale 1ns/1ps

module tb_clock_gen (
  output logic clk,
  output logic rst
);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk; // 10 ns period
  end

  // reset covers the first two rising edges
  initial begin
    rst = 1'b1;
    repeat (2) @(posedge clk);
    #1 rst = 1'b0;
  end

endmodule
